// File: compile.f
+incdir+tb
verilog/qnet_pkg.sv
verilog/qnet_param_regs.sv
verilog/qnet_ctrl_sched.sv
verilog/qnet_sync_core.sv
tb/qnet_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= qnet_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/qnet_tb_checks.svh
`ifndef QNET_TB_CHECKS_SVH
`define QNET_TB_CHECKS_SVH

//////////////////////////////
// compare tasks
//////////////////////////////

// parameter words and timestamps
task automatic check_word(input string name,
                          input logic [qnet_pkg::STAMP_W-1:0] got,
                          input logic [qnet_pkg::STAMP_W-1:0] exp);
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_err++;
   end
endtask

// node count and node id
task automatic check_node(input string name,
                          input logic [qnet_pkg::NODE_W-1:0] got,
                          input logic [qnet_pkg::NODE_W-1:0] exp);
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_err++;
   end
endtask

// stop, start, time reset packed by control id bit position
task automatic check_pulse(input string name,
                           input qnet_pkg::ctrl_id_t got,
                           input qnet_pkg::ctrl_id_t exp);
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_err++;
   end
endtask

task automatic check_cnt(input string name,
                         input logic [ERR_CNT_W-1:0] got,
                         input logic [ERR_CNT_W-1:0] exp);
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_err++;
   end
endtask

// single status flags
task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      test_err++;
   end
endtask

`endif

// File: tb/qnet_tb.sv
`timescale 1ns/100ps

module qnet_tb;

   localparam int ERR_CNT_W = 4;
   localparam int CLK_PERIOD = 4;
   localparam int RST_CYC = 8;
   localparam int N_PARAM = 40;
   localparam int N_EV = 40;
   localparam int N_REQ = 10;
   localparam int REQ_MAX = 40;   // wait bound per request
   localparam int N_REJ = 8;
   localparam int N_STRB = 30;
   localparam int TOTAL_CYCLES = RST_CYC + N_PARAM + N_EV + (N_REQ + N_REJ + 2) * (REQ_MAX + 8)
                                 + N_REJ * 4 + N_STRB + 20;

   logic t_clk_i = 1'b0;
   logic ps_rst_ni = 1'b0;
   logic [qnet_pkg::TIME_W-1:0] t_time_abs_i;
   logic param_we_i = 1'b0;
   qnet_pkg::param_sel_t param_sel_i = qnet_pkg::SEL_OFF;
   logic [63:0] param_dt_i = '0;
   logic ev_net_cmd_i = 1'b0, ev_loc_cmd_i = 1'b0, ev_link_cc_i = 1'b0, ev_link_rdy_i = 1'b0;
   logic ctrl_req_i = 1'b0;
   qnet_pkg::ctrl_id_t ctrl_id_i = '0;
   logic [qnet_pkg::TIME_W-1:0] ctrl_time_i = '0;
   logic time_reset_i = 1'b0, time_init_i = 1'b0, time_updt_i = 1'b0;

   logic [qnet_pkg::STAMP_W-1:0] time_off_dt_o, tnet_dt1_o, tnet_dt2_o, rtd_o;
   logic [qnet_pkg::STAMP_W-1:0] t_ncr_o, t_lcs_o, t_lcc_o, t_ltr_o;
   logic [qnet_pkg::NODE_W-1:0]  node_nn_o, node_id_o;
   logic ctrl_busy_o, core_start_o, core_stop_o, time_rst_o, time_init_o, time_updt_o;
   logic [ERR_CNT_W-1:0] ctrl_err_cnt_o;

   // next-cycle stimulus, applied at the rising edge
   logic nx_we, nx_req, nx_rst, nx_init, nx_updt;
   qnet_pkg::param_sel_t nx_sel;
   logic [63:0] nx_dt;
   logic [3:0] nx_ev;
   qnet_pkg::ctrl_id_t nx_id;
   logic [qnet_pkg::TIME_W-1:0] nx_time;

   // reference model state
   logic [qnet_pkg::STAMP_W-1:0] m_off, m_rtd, m_dt1, m_dt2, m_ncr, m_lcs, m_lcc, m_ltr;
   logic [qnet_pkg::NODE_W-1:0]  m_nn, m_id;
   logic m_pend, m_exec_vld, m_init, m_updt;
   logic [qnet_pkg::TIME_W-1:0] m_target;
   qnet_pkg::ctrl_id_t m_pend_id, m_exec_id, m_pulse;   // m_pulse is {stop, start, trst}
   logic [ERR_CNT_W-1:0] m_cnt;

   int test_err = 0;
   int test_cnt = 0;
   int fail_cnt = 0;
   int rtd_val;

   `include "qnet_tb_checks.svh"

   qnet_sync_core #(.ERR_CNT_W(ERR_CNT_W)) dut_i (.*);

   always #(CLK_PERIOD / 2) t_clk_i = ~t_clk_i;

   initial begin
      #(2 * TOTAL_CYCLES * CLK_PERIOD);
      $display("watchdog expired, a test did not finish in time");
      $display("Test failures found");
      $finish;
   end

   task automatic model_reset();
      {m_off, m_rtd, m_dt1, m_dt2, m_ncr, m_lcs, m_lcc, m_ltr} = '0;
      {m_nn, m_id, m_pend, m_exec_vld, m_init, m_updt} = '0;
      {m_target, m_pend_id, m_exec_id, m_pulse, m_cnt} = '0;
   endtask

   // one clock edge of the expected behavior, from the inputs sampled there
   task automatic model_edge();
      logic signed [qnet_pkg::TIME_W-1:0] lead;
      logic late, vld, due;
      lead = $signed(ctrl_time_i - t_time_abs_i);
      late = lead < $signed({16'd0, m_rtd});
      vld  = ctrl_req_i && (ctrl_id_i != '0);
      due  = m_pend && !(t_time_abs_i - m_target >= 48'h8000_0000_0000);
      m_pulse[qnet_pkg::CTRL_START] = m_exec_vld & m_exec_id[qnet_pkg::CTRL_START];
      m_pulse[qnet_pkg::CTRL_STOP]  = m_exec_vld & m_exec_id[qnet_pkg::CTRL_STOP];
      m_pulse[qnet_pkg::CTRL_TRST]  = time_reset_i | (m_exec_vld & m_exec_id[qnet_pkg::CTRL_TRST]);
      m_init = time_init_i;
      m_updt = time_updt_i;
      m_exec_vld = due;
      if (due) m_exec_id = m_pend_id;
      if (vld && (m_pend || late) && m_cnt != '1) m_cnt++;
      if (due) begin
         m_pend = 1'b0;
      end else if (vld && !m_pend && !late) begin
         m_pend = 1'b1;
         m_target = ctrl_time_i;
         m_pend_id = ctrl_id_i;
      end
      if (param_we_i) begin
         case (param_sel_i)
            qnet_pkg::SEL_OFF: m_off = param_dt_i[31:0];
            qnet_pkg::SEL_RTD: m_rtd = param_dt_i[31:0];
            qnet_pkg::SEL_NN:  m_nn  = param_dt_i[9:0];
            qnet_pkg::SEL_ID:  m_id  = param_dt_i[9:0];
            default: {m_dt2, m_dt1} = param_dt_i;
         endcase
      end
      if (ev_net_cmd_i)  m_ncr = t_time_abs_i[31:0];
      if (ev_loc_cmd_i)  m_lcs = t_time_abs_i[31:0];
      if (ev_link_cc_i)  m_lcc = t_time_abs_i[31:0];
      if (ev_link_rdy_i) m_ltr = t_time_abs_i[31:0];
   endtask

   task automatic compare_all();
      check_word("time_off_dt_o", time_off_dt_o, m_off);
      check_word("rtd_o", rtd_o, m_rtd);
      check_word("tnet_dt1_o", tnet_dt1_o, m_dt1);
      check_word("tnet_dt2_o", tnet_dt2_o, m_dt2);
      check_node("node_nn_o", node_nn_o, m_nn);
      check_node("node_id_o", node_id_o, m_id);
      check_word("t_ncr_o", t_ncr_o, m_ncr);
      check_word("t_lcs_o", t_lcs_o, m_lcs);
      check_word("t_lcc_o", t_lcc_o, m_lcc);
      check_word("t_ltr_o", t_ltr_o, m_ltr);
      check_pulse("core_stop_o,core_start_o,time_rst_o",
                  {core_stop_o, core_start_o, time_rst_o}, m_pulse);
      check_bit("ctrl_busy_o", ctrl_busy_o, m_pend);
      check_bit("time_init_o", time_init_o, m_init);
      check_bit("time_updt_o", time_updt_o, m_updt);
      check_cnt("ctrl_err_cnt_o", ctrl_err_cnt_o, m_cnt);
   endtask

   task automatic clear_next();
      {nx_we, nx_req, nx_rst, nx_init, nx_updt, nx_ev, nx_dt, nx_id, nx_time} = '0;
      nx_sel = qnet_pkg::SEL_OFF;
   endtask

   task automatic tick();
      @(posedge t_clk_i);
      if (!ps_rst_ni) model_reset();
      else model_edge();
      param_we_i <= nx_we;
      param_sel_i <= nx_sel;
      param_dt_i <= nx_dt;
      {ev_net_cmd_i, ev_loc_cmd_i, ev_link_cc_i, ev_link_rdy_i} <= nx_ev;
      ctrl_req_i <= nx_req;
      ctrl_id_i <= nx_id;
      ctrl_time_i <= nx_time;
      time_reset_i <= nx_rst;
      time_init_i <= nx_init;
      time_updt_i <= nx_updt;
      t_time_abs_i <= t_time_abs_i + 1'b1;
      clear_next();
      @(negedge t_clk_i);
      compare_all();
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (test_err != 0) fail_cnt++;
      $display("test %-10s %s (%0d errors)", name, (test_err == 0) ? "ok" : "FAILED", test_err);
      test_err = 0;
   endtask

   // request relative to the time the DUT samples on the next edge
   task automatic request(input int lead, input qnet_pkg::ctrl_id_t id);
      nx_req = 1'b1;
      nx_id = id;
      nx_time = t_time_abs_i + 1'b1 + 48'(lead);
   endtask

   // first edge takes the request on the inputs, then wait for execution
   task automatic drain();
      int w;
      w = 0;
      tick();
      while (m_pend && w < REQ_MAX) begin
         tick();
         w++;
      end
      if (m_pend) begin
         $display("pending request never executed");
         test_err++;
      end
      repeat (3) tick();
   endtask

   initial begin
      void'($urandom(88782));
      t_time_abs_i = {$urandom(), 16'($urandom())};
      clear_next();
      repeat (RST_CYC) tick();
      @(posedge t_clk_i);
      ps_rst_ni <= 1'b1;
      @(negedge t_clk_i);
      compare_all();
      end_test("reset");

      repeat (N_PARAM) begin
         nx_we = 1'b1;
         nx_sel = qnet_pkg::param_sel_t'(3'($urandom_range(4, 0)));
         nx_dt = {$urandom(), $urandom()};
         tick();
      end
      tick();
      end_test("params");

      repeat (N_EV) begin
         nx_ev = 4'($urandom());
         tick();
      end
      tick();
      end_test("events");

      ////////////////////////////// scheduling
      rtd_val = 5 + $urandom_range(15, 0);
      nx_we = 1'b1;
      nx_sel = qnet_pkg::SEL_RTD;
      nx_dt = 64'(rtd_val);
      tick();
      repeat (N_REQ) begin
         request(rtd_val + 1 + $urandom_range(11, 0), 3'(1 + $urandom_range(6, 0)));
         tick();
         drain();
      end
      end_test("schedule");

      repeat (N_REJ) begin
         request(rtd_val - 1 - $urandom_range(30, 0), 3'(1 + $urandom_range(6, 0)));
         tick();
         request(rtd_val + 4, 3'(1 + $urandom_range(6, 0)));
         tick();
         request(rtd_val + 8, 3'(1 + $urandom_range(6, 0)));   // rejected while busy
         tick();
         request(rtd_val + 8, 3'd0);   // ignored
         tick();
         drain();
      end
      check_cnt("ctrl_err_cnt_o", ctrl_err_cnt_o, '1);
      end_test("reject");

      repeat (N_STRB) begin
         {nx_rst, nx_init, nx_updt} = 3'($urandom());
         tick();
      end
      request(rtd_val + 2, 3'b001);   // scheduled time reset only
      tick();
      drain();
      end_test("strobes");

      $display("%0d tests run, %0d failed", test_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: verilog/qnet_sync_core.sv
`timescale 1ns/100ps

module qnet_sync_core #(
   parameter int unsigned ERR_CNT_W = 4
) (
   input  logic                           t_clk_i,
   input  logic                           ps_rst_ni,
   input  logic [qnet_pkg::TIME_W-1:0]    t_time_abs_i,
   // parameter write
   input  logic                           param_we_i,
   input  qnet_pkg::param_sel_t           param_sel_i,
   input  logic [2*qnet_pkg::STAMP_W-1:0] param_dt_i,
   // link and command events
   input  logic                           ev_net_cmd_i,
   input  logic                           ev_loc_cmd_i,
   input  logic                           ev_link_cc_i,
   input  logic                           ev_link_rdy_i,
   // scheduled control
   input  logic                           ctrl_req_i,
   input  qnet_pkg::ctrl_id_t             ctrl_id_i,
   input  logic [qnet_pkg::TIME_W-1:0]    ctrl_time_i,
   // processor time strobes
   input  logic                           time_reset_i,
   input  logic                           time_init_i,
   input  logic                           time_updt_i,
   // node parameters
   output logic [qnet_pkg::STAMP_W-1:0]   time_off_dt_o,
   output logic [qnet_pkg::STAMP_W-1:0]   tnet_dt1_o,
   output logic [qnet_pkg::STAMP_W-1:0]   tnet_dt2_o,
   output logic [qnet_pkg::NODE_W-1:0]    node_nn_o,
   output logic [qnet_pkg::NODE_W-1:0]    node_id_o,
   output logic [qnet_pkg::STAMP_W-1:0]   rtd_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_ncr_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_lcs_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_lcc_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_ltr_o,
   // control status and actions
   output logic                           ctrl_busy_o,
   output logic [ERR_CNT_W-1:0]           ctrl_err_cnt_o,
   output logic                           core_start_o,
   output logic                           core_stop_o,
   output logic                           time_rst_o,
   output logic                           time_init_o,
   output logic                           time_updt_o
);

   logic [qnet_pkg::STAMP_W-1:0] rtd;   // also feeds the lateness check

   assign rtd_o = rtd;

   qnet_param_regs param_regs_i (
      .t_clk_i       ( t_clk_i       ),
      .ps_rst_ni     ( ps_rst_ni     ),
      .param_we_i    ( param_we_i    ),
      .param_sel_i   ( param_sel_i   ),
      .param_dt_i    ( param_dt_i    ),
      .t_time_abs_i  ( t_time_abs_i  ),
      .ev_net_cmd_i  ( ev_net_cmd_i  ),
      .ev_loc_cmd_i  ( ev_loc_cmd_i  ),
      .ev_link_cc_i  ( ev_link_cc_i  ),
      .ev_link_rdy_i ( ev_link_rdy_i ),
      .rtd_o         ( rtd           ),
      .time_off_dt_o ( time_off_dt_o ),
      .tnet_dt1_o    ( tnet_dt1_o    ),
      .tnet_dt2_o    ( tnet_dt2_o    ),
      .node_nn_o     ( node_nn_o     ),
      .node_id_o     ( node_id_o     ),
      .t_ncr_o       ( t_ncr_o       ),
      .t_lcs_o       ( t_lcs_o       ),
      .t_lcc_o       ( t_lcc_o       ),
      .t_ltr_o       ( t_ltr_o       )
   );

   qnet_ctrl_sched #(
      .ERR_CNT_W ( ERR_CNT_W )
   ) ctrl_sched_i (
      .t_clk_i        ( t_clk_i        ),
      .ps_rst_ni      ( ps_rst_ni      ),
      .t_time_abs_i   ( t_time_abs_i   ),
      .rtd_i          ( rtd            ),
      .ctrl_req_i     ( ctrl_req_i     ),
      .ctrl_id_i      ( ctrl_id_i      ),
      .ctrl_time_i    ( ctrl_time_i    ),
      .time_reset_i   ( time_reset_i   ),
      .time_init_i    ( time_init_i    ),
      .time_updt_i    ( time_updt_i    ),
      .ctrl_busy_o    ( ctrl_busy_o    ),
      .ctrl_err_cnt_o ( ctrl_err_cnt_o ),
      .core_start_o   ( core_start_o   ),
      .core_stop_o    ( core_stop_o    ),
      .time_rst_o     ( time_rst_o     ),
      .time_init_o    ( time_init_o    ),
      .time_updt_o    ( time_updt_o    )
   );

endmodule

// File: verilog/qnet_ctrl_sched.sv
`timescale 1ns/100ps

module qnet_ctrl_sched #(
   parameter int unsigned ERR_CNT_W = 4
) (
   input  logic                         t_clk_i,
   input  logic                         ps_rst_ni,
   input  logic [qnet_pkg::TIME_W-1:0]  t_time_abs_i,
   input  logic [qnet_pkg::STAMP_W-1:0] rtd_i,
   // control request
   input  logic                         ctrl_req_i,
   input  qnet_pkg::ctrl_id_t           ctrl_id_i,
   input  logic [qnet_pkg::TIME_W-1:0]  ctrl_time_i,
   // processor time strobes
   input  logic                         time_reset_i,
   input  logic                         time_init_i,
   input  logic                         time_updt_i,
   // status
   output logic                         ctrl_busy_o,
   output logic [ERR_CNT_W-1:0]         ctrl_err_cnt_o,
   // action pulses
   output logic                         core_start_o,
   output logic                         core_stop_o,
   output logic                         time_rst_o,
   output logic                         time_init_o,
   output logic                         time_updt_o
);

   localparam int unsigned PAD_W = qnet_pkg::TIME_W - qnet_pkg::STAMP_W;

   // pending request
   logic                        pend_r;
   logic [qnet_pkg::TIME_W-1:0] pend_time_r;
   qnet_pkg::ctrl_id_t          pend_id_r;

   // execute stage, valid for one cycle
   logic                        exec_vld_r;
   qnet_pkg::ctrl_id_t          exec_id_r;

   logic [ERR_CNT_W-1:0]        err_cnt_r;

   logic signed [qnet_pkg::TIME_W-1:0] lead_time;
   logic signed [qnet_pkg::TIME_W-1:0] rtd_ext;
   logic signed [qnet_pkg::TIME_W-1:0] left_time;

   logic req_vld;
   logic req_late;
   logic req_accept;
   logic req_reject;
   logic exec_due;

   //////////////////////////////
   // request judgement
   //////////////////////////////

   // lead time is signed so a target in the past reads negative
   assign lead_time = ctrl_time_i - t_time_abs_i;
   assign rtd_ext   = {{PAD_W{1'b0}}, rtd_i};
   assign req_late  = lead_time < rtd_ext;

   assign req_vld    = ctrl_req_i & (|ctrl_id_i);   // zero id asks for nothing
   assign req_accept = req_vld & ~pend_r & ~req_late;
   assign req_reject = req_vld & (pend_r | req_late);

   // sign of (now - target) clear means target reached
   assign left_time = t_time_abs_i - pend_time_r;
   assign exec_due  = pend_r & ~left_time[qnet_pkg::TIME_W-1];

   //////////////////////////////
   // pending command
   //////////////////////////////

   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         pend_r      <= 1'b0;
         pend_time_r <= '0;
         pend_id_r   <= '0;
      end else begin
         if (exec_due) begin
            pend_r <= 1'b0;
         end else if (req_accept) begin
            pend_r      <= 1'b1;
            pend_time_r <= ctrl_time_i;
            pend_id_r   <= ctrl_id_i;
         end
      end
   end

   assign ctrl_busy_o = pend_r;

   // saturating reject count
   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         err_cnt_r <= '0;
      end else if (req_reject && (err_cnt_r != '1)) begin
         err_cnt_r <= err_cnt_r + 1'b1;
      end
   end

   assign ctrl_err_cnt_o = err_cnt_r;

   //////////////////////////////
   // execution
   //////////////////////////////

   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         exec_vld_r <= 1'b0;
         exec_id_r  <= '0;
      end else begin
         exec_vld_r <= exec_due;
         if (exec_due) exec_id_r <= pend_id_r;
      end
   end

   // action pulses one edge after the execute stage
   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         core_start_o <= 1'b0;
         core_stop_o  <= 1'b0;
         time_rst_o   <= 1'b0;
         time_init_o  <= 1'b0;
         time_updt_o  <= 1'b0;
      end else begin
         core_start_o <= exec_vld_r & exec_id_r[qnet_pkg::CTRL_START];
         core_stop_o  <= exec_vld_r & exec_id_r[qnet_pkg::CTRL_STOP];
         // processor reset or scheduled reset
         time_rst_o   <= time_reset_i | (exec_vld_r & exec_id_r[qnet_pkg::CTRL_TRST]);
         time_init_o  <= time_init_i;
         time_updt_o  <= time_updt_i;
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   // only accepted ids with a set bit may reach execute
   a_exec_id_nonzero : assert property (
      @(posedge t_clk_i) disable iff (!ps_rst_ni)
      exec_vld_r |-> (exec_id_r != '0)
   ) else $error("execute stage holds a zero control id");

   // a new request cannot be taken before the old one has left pending
   a_pend_exec_excl : assert property (
      @(posedge t_clk_i) disable iff (!ps_rst_ni)
      !(pend_r && exec_vld_r)
   ) else $error("pending and execute set together");

   a_err_cnt_no_wrap : assert property (
      @(posedge t_clk_i) disable iff (!ps_rst_ni)
      (err_cnt_r == '1) |=> (err_cnt_r == '1)
   ) else $error("reject counter wrapped");

endmodule

// File: verilog/qnet_param_regs.sv
`timescale 1ns/100ps

module qnet_param_regs (
   input  logic                           t_clk_i,
   input  logic                           ps_rst_ni,
   // parameter write port
   input  logic                           param_we_i,
   input  qnet_pkg::param_sel_t           param_sel_i,
   input  logic [2*qnet_pkg::STAMP_W-1:0] param_dt_i,
   // timestamp sources
   input  logic [qnet_pkg::TIME_W-1:0]    t_time_abs_i,
   input  logic                           ev_net_cmd_i,
   input  logic                           ev_loc_cmd_i,
   input  logic                           ev_link_cc_i,
   input  logic                           ev_link_rdy_i,
   // node configuration
   output logic [qnet_pkg::STAMP_W-1:0]   rtd_o,
   output logic [qnet_pkg::STAMP_W-1:0]   time_off_dt_o,
   output logic [qnet_pkg::STAMP_W-1:0]   tnet_dt1_o,
   output logic [qnet_pkg::STAMP_W-1:0]   tnet_dt2_o,
   output logic [qnet_pkg::NODE_W-1:0]    node_nn_o,
   output logic [qnet_pkg::NODE_W-1:0]    node_id_o,
   // captured event times
   output logic [qnet_pkg::STAMP_W-1:0]   t_ncr_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_lcs_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_lcc_o,
   output logic [qnet_pkg::STAMP_W-1:0]   t_ltr_o
);

   logic [qnet_pkg::STAMP_W-1:0] param_32_dt;
   logic [qnet_pkg::NODE_W-1:0]  param_10_dt;
   logic [qnet_pkg::STAMP_W-1:0] time_stamp;

   assign param_32_dt = param_dt_i[qnet_pkg::STAMP_W-1:0];
   assign param_10_dt = param_dt_i[qnet_pkg::NODE_W-1:0];
   assign time_stamp  = t_time_abs_i[qnet_pkg::STAMP_W-1:0];   // low word only

   //////////////////////////////
   // node parameters
   //////////////////////////////

   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         time_off_dt_o <= '0;
         rtd_o         <= '0;
         node_nn_o     <= '0;
         node_id_o     <= '0;
         tnet_dt1_o    <= '0;
         tnet_dt2_o    <= '0;
      end else if (param_we_i) begin
         case (param_sel_i)
            qnet_pkg::SEL_OFF: time_off_dt_o <= param_32_dt;
            qnet_pkg::SEL_RTD: rtd_o         <= param_32_dt;
            qnet_pkg::SEL_NN:  node_nn_o     <= param_10_dt;
            qnet_pkg::SEL_ID:  node_id_o     <= param_10_dt;
            qnet_pkg::SEL_DT: begin
               tnet_dt2_o <= param_dt_i[2*qnet_pkg::STAMP_W-1:qnet_pkg::STAMP_W];
               tnet_dt1_o <= param_dt_i[qnet_pkg::STAMP_W-1:0];
            end
            default: ;   // unused codes write nothing
         endcase
      end
   end

   //////////////////////////////
   // event timestamps
   //////////////////////////////

   // each event has its own stamp, several may fire together
   always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         t_ncr_o <= '0;
         t_lcs_o <= '0;
         t_lcc_o <= '0;
         t_ltr_o <= '0;
      end else begin
         if (ev_net_cmd_i)  t_ncr_o <= time_stamp;   // network command received
         if (ev_loc_cmd_i)  t_lcs_o <= time_stamp;   // local command sent
         if (ev_link_cc_i)  t_lcc_o <= time_stamp;   // link cycle complete
         if (ev_link_rdy_i) t_ltr_o <= time_stamp;   // link ready
      end
   end

   // the source may only use the five decoded codes
   a_sel_code_valid : assert property (
      @(posedge t_clk_i) disable iff (!ps_rst_ni)
      param_we_i |-> param_sel_i inside {qnet_pkg::SEL_OFF, qnet_pkg::SEL_RTD,
                                         qnet_pkg::SEL_NN,  qnet_pkg::SEL_ID,
                                         qnet_pkg::SEL_DT}
   ) else $error("param write with undefined select code %0d", param_sel_i);

endmodule

// File: verilog/qnet_pkg.sv
package qnet_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // absolute time counter
   localparam int unsigned TIME_W    = 48;

   // timestamps and parameter words
   localparam int unsigned STAMP_W   = 32;

   // node count and node id
   localparam int unsigned NODE_W    = 10;

   // one bit per requested action
   localparam int unsigned CTRL_ID_W = 3;

   //////////////////////////////
   // control id bit positions
   //////////////////////////////

   localparam int unsigned CTRL_TRST  = 0;   // time reset
   localparam int unsigned CTRL_START = 1;   // core start
   localparam int unsigned CTRL_STOP  = 2;   // core stop

   typedef logic [CTRL_ID_W-1:0] ctrl_id_t;

   //////////////////////////////
   // parameter select codes
   //////////////////////////////

   // codes 5..7 are not decoded
   typedef enum logic [2:0] {
      SEL_OFF = 3'd0,   // time offset
      SEL_RTD = 3'd1,   // round trip delay
      SEL_NN  = 3'd2,   // node count
      SEL_ID  = 3'd3,   // node id
      SEL_DT  = 3'd4    // dt2 and dt1 data pair
   } param_sel_t;

endpackage
